//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_debug_system
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_TEXT ?= test failed
PASS_TEXT ?= test passed

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "make clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "make help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG) || ! grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation FAILED, see $(LOG)"; exit 1; \
	fi
	@echo "Simulation PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/tb_debug_system.sv
`timescale 1ns/1ps
`include "dbg_macros.svh"

module tb_debug_system;

   localparam int TIMEOUT = 1000;
   localparam int FLIT_W = `DBG_FLIT_TYPE_W + `DBG_FLIT_DATA_W;
   localparam logic [1:0] T_PAYLOAD = 2'd0;
   localparam logic [1:0] T_HEADER = 2'd1;
   localparam logic [1:0] T_LAST = 2'd2;
   localparam logic [1:0] T_SINGLE = 2'd3;
   localparam logic [`DBG_CLASS_W-1:0] C_INFO = 3'd0;
   localparam logic [`DBG_CLASS_W-1:0] C_CTRL = 3'd1;
   localparam logic [`DBG_CLASS_W-1:0] C_TRACE = 3'd2;
   localparam logic [`DBG_DEST_W-1:0] ADDR_EXT = `DBG_DEST_W'(`DBG_ADDR_EXT);
   localparam logic [`DBG_DEST_W-1:0] ADDR_TCM = `DBG_DEST_W'(`DBG_ADDR_TCM);
   localparam logic [`DBG_DEST_W-1:0] ADDR_STM = `DBG_DEST_W'(`DBG_ADDR_STM);
   localparam logic [`DBG_SRC_W-1:0] SRC_HOST = `DBG_SRC_W'(`DBG_ADDR_EXT);
   localparam logic [`DBG_SRC_W-1:0] SRC_TCM = `DBG_SRC_W'(`DBG_ADDR_TCM);
   localparam logic [`DBG_SRC_W-1:0] SRC_STM = `DBG_SRC_W'(`DBG_ADDR_STM);

   logic                          clk;
   logic                          reset_i;
   logic [FLIT_W-1:0]             dbgnoc_in_flit_i;
   logic                          dbgnoc_in_valid_i;
   logic                          dbgnoc_in_ready_o;
   logic [FLIT_W-1:0]             dbgnoc_out_flit_o;
   logic                          dbgnoc_out_valid_o;
   logic                          dbgnoc_out_ready_i;
   logic                          trace_valid_i;
   logic [`DBG_TRACE_ID_W-1:0]    trace_id_i;
   logic [`DBG_TRACE_VALUE_W-1:0] trace_value_i;
   logic                          cpu_stall_o;
   logic                          cpu_reset_o;
   logic                          start_cpu_o;
   logic                          bp_on;
   logic [FLIT_W-1:0]             expected_q [$];

   debug_system i_dut (
      .clk                (clk),
      .reset_i            (reset_i),
      .dbgnoc_in_flit_i   (dbgnoc_in_flit_i),
      .dbgnoc_in_valid_i  (dbgnoc_in_valid_i),
      .dbgnoc_in_ready_o  (dbgnoc_in_ready_o),
      .dbgnoc_out_flit_o  (dbgnoc_out_flit_o),
      .dbgnoc_out_valid_o (dbgnoc_out_valid_o),
      .dbgnoc_out_ready_i (dbgnoc_out_ready_i),
      .trace_valid_i      (trace_valid_i),
      .trace_id_i         (trace_id_i),
      .trace_value_i      (trace_value_i),
      .cpu_stall_o        (cpu_stall_o),
      .cpu_reset_o        (cpu_reset_o),
      .start_cpu_o        (start_cpu_o)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Random stalls on the external output while back-pressure is on
   always @(posedge clk) begin
      if (bp_on) begin
         dbgnoc_out_ready_i <= ($urandom_range(1, 0) == 1);
      end else begin
         dbgnoc_out_ready_i <= 1'b1;
      end
   end

   task automatic stop_on_error(input string line);
      $display("%s", line);
      $display("test failed");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic check(input bit ok, input string what);
      assert (ok) else stop_on_error($sformatf("CHECK FAILED at %0t ns: %s", $time, what));
   endtask

   a_out_hold: assert property (@(posedge clk) disable iff (reset_i)
      dbgnoc_out_valid_o && !dbgnoc_out_ready_i |=>
         dbgnoc_out_valid_o && $stable(dbgnoc_out_flit_o))
      else stop_on_error($sformatf("CHECK FAILED at %0t ns: %s", $time,
         "dbgnoc_out changed while stalled"));

   // Header word with destination above class above source
   function automatic logic [`DBG_FLIT_DATA_W-1:0] header_word(
      input logic [`DBG_DEST_W-1:0] dest,
      input logic [`DBG_CLASS_W-1:0] cls,
      input logic [`DBG_SRC_W-1:0] src
   );
      return {dest, cls, src};
   endfunction

   task automatic send_flit(input logic [FLIT_W-1:0] flit);
      int waited;
      waited = 0;
      dbgnoc_in_flit_i <= flit;
      dbgnoc_in_valid_i <= 1'b1;
      @(posedge clk);
      while (!dbgnoc_in_ready_o && waited < TIMEOUT) begin
         @(posedge clk);
         waited++;
      end
      if (!dbgnoc_in_ready_o) begin
         stop_on_error($sformatf("Timeout at %0t ns: dbgnoc_in never took a flit", $time));
      end
   endtask

   task automatic receive_flit(output logic [FLIT_W-1:0] flit);
      int waited;
      waited = 0;
      @(posedge clk);
      while (!(dbgnoc_out_valid_o && dbgnoc_out_ready_i) && waited < TIMEOUT) begin
         @(posedge clk);
         waited++;
      end
      if (!(dbgnoc_out_valid_o && dbgnoc_out_ready_i)) begin
         stop_on_error($sformatf("Timeout at %0t ns: no flit arrived on dbgnoc_out", $time));
      end
      flit = dbgnoc_out_flit_o;
   endtask

   task automatic send_ctrl(input logic [`DBG_DEST_W-1:0] dest, input logic [2:0] bits);
      send_flit({T_HEADER, header_word(dest, C_CTRL, SRC_HOST)});
      send_flit({T_LAST, {(`DBG_FLIT_DATA_W-3){1'b0}}, bits});
      dbgnoc_in_valid_i <= 1'b0;
   endtask

   task automatic wait_cpu_bits(input logic [2:0] bits);
      int waited;
      waited = 0;
      while ({start_cpu_o, cpu_reset_o, cpu_stall_o} != bits && waited < TIMEOUT) begin
         @(posedge clk);
         waited++;
      end
      check({start_cpu_o, cpu_reset_o, cpu_stall_o} == bits,
         $sformatf("CPU control lines never showed %b", bits));
   endtask

   task automatic request_info();
      logic [FLIT_W-1:0] got;
      expected_q.push_back({T_HEADER, header_word(ADDR_EXT, C_INFO, SRC_TCM)});
      expected_q.push_back({T_PAYLOAD, `DBG_SYSTEM_ID});
      expected_q.push_back({T_LAST, `DBG_MODULE_COUNT});
      send_flit({T_SINGLE, header_word(ADDR_TCM, C_INFO, SRC_HOST)});
      dbgnoc_in_valid_i <= 1'b0;
      while (expected_q.size() > 0) begin
         receive_flit(got);
         check(got == expected_q[0],
            $sformatf("info reply flit %h, expected %h", got, expected_q[0]));
         void'(expected_q.pop_front());
      end
   endtask

   // Event stays valid until its header shows up, which covers the enable latency
   task automatic trace_event(output logic [`DBG_TIMESTAMP_W-1:0] ts);
      logic [`DBG_TRACE_ID_W-1:0]    id;
      logic [`DBG_TRACE_VALUE_W-1:0] value;
      logic [FLIT_W-1:0]             got;
      logic [FLIT_W-1:0]             body [5];
      id = `DBG_TRACE_ID_W'($urandom);
      value = $urandom;
      trace_id_i <= id;
      trace_value_i <= value;
      trace_valid_i <= 1'b1;
      receive_flit(got);
      // STM is still mid-packet here, so no second capture
      trace_valid_i <= 1'b0;
      check(got == {T_HEADER, header_word(ADDR_EXT, C_TRACE, SRC_STM)},
         $sformatf("trace header %h", got));
      for (int i = 0; i < 5; i++) begin
         receive_flit(body[i]);
         check(body[i][FLIT_W-1 -: 2] == ((i == 4) ? T_LAST : T_PAYLOAD),
            $sformatf("trace flit %0d has type %0d", i, body[i][FLIT_W-1 -: 2]));
      end
      check(body[2][`DBG_FLIT_DATA_W-1:0] == id, "trace id differs from the driven id");
      check({body[3][`DBG_FLIT_DATA_W-1:0], body[4][`DBG_FLIT_DATA_W-1:0]} == value,
         "trace value differs from the driven value");
      ts = {body[0][`DBG_FLIT_DATA_W-1:0], body[1][`DBG_FLIT_DATA_W-1:0]};
   endtask

   task automatic watch_quiet(input int cycles);
      trace_id_i <= `DBG_TRACE_ID_W'($urandom);
      trace_value_i <= $urandom;
      trace_valid_i <= 1'b1;
      repeat (cycles) begin
         @(posedge clk);
         check(!dbgnoc_out_valid_o, "flit on dbgnoc_out while tracing is off");
      end
      trace_valid_i <= 1'b0;
   endtask

   initial begin
      logic [2:0]                  bits;
      logic [`DBG_TIMESTAMP_W-1:0] ts;
      logic [`DBG_TIMESTAMP_W-1:0] prev_ts;
      void'($urandom(83130));
      reset_i = 1'b1;
      dbgnoc_in_flit_i = '0;
      dbgnoc_in_valid_i = 1'b0;
      dbgnoc_out_ready_i = 1'b1;
      trace_valid_i = 1'b0;
      trace_id_i = '0;
      trace_value_i = '0;
      bp_on = 1'b0;
      repeat (8) @(posedge clk);
      reset_i <= 1'b0;
      @(posedge clk);
      check(!dbgnoc_out_valid_o, "dbgnoc_out_valid_o high after reset");
      check({start_cpu_o, cpu_reset_o, cpu_stall_o} == 3'b000, "CPU lines high after reset");
      request_info();
      // Each write flips at least one line so that it is seen arriving
      bits = 3'b000;
      repeat (6) begin
         bits = bits ^ 3'($urandom_range(7, 1));
         send_ctrl(ADDR_TCM, bits);
         wait_cpu_bits(bits);
      end
      // CPU running while tracing stays off from reset
      send_ctrl(ADDR_TCM, 3'b100);
      wait_cpu_bits(3'b100);
      watch_quiet(50);
      bp_on <= 1'b1;
      request_info();
      send_ctrl(ADDR_STM, 3'b001);
      prev_ts = '0;
      repeat (5) begin
         trace_event(ts);
         check(ts > prev_ts, $sformatf("timestamp %0d not above %0d", ts, prev_ts));
         prev_ts = ts;
      end
      // Restarting the CPU restarts the timestamp
      send_ctrl(ADDR_TCM, 3'b000);
      wait_cpu_bits(3'b000);
      send_ctrl(ADDR_TCM, 3'b100);
      wait_cpu_bits(3'b100);
      trace_event(ts);
      check(ts < prev_ts, $sformatf("timestamp %0d after restart, %0d before", ts, prev_ts));
      $display("test passed");
      $finish;
   end

endmodule

//--- build.f
+incdir+include
hdl/dbg_pkg.sv
hdl/dbg_ring_router.sv
hdl/dbg_ring.sv
hdl/dbg_tcm.sv
hdl/dbg_stm.sv
hdl/debug_system.sv
bench/tb_debug_system.sv

//--- hdl/dbg_pkg.sv
`include "dbg_macros.svh"

package dbg_pkg;

   typedef logic [`DBG_FLIT_DATA_W-1:0] dbg_data_t;
   typedef logic [`DBG_FLIT_TYPE_W+`DBG_FLIT_DATA_W-1:0] dbg_flit_t;
   typedef logic [`DBG_DEST_W-1:0] dbg_addr_t;
   typedef logic [`DBG_TIMESTAMP_W-1:0] timestamp_t;
   typedef logic [`DBG_TRACE_ID_W-1:0] trace_id_t;
   typedef logic [`DBG_TRACE_VALUE_W-1:0] trace_value_t;

   typedef enum logic [`DBG_FLIT_TYPE_W-1:0] {
      PAYLOAD = 2'd0,
      HEADER  = 2'd1,
      LAST    = 2'd2,
      SINGLE  = 2'd3
   } flit_type_e;

   typedef enum logic [`DBG_CLASS_W-1:0] {
      CLASS_INFO  = 3'd0,
      CLASS_CTRL  = 3'd1,
      CLASS_TRACE = 3'd2
   } pkt_class_e;

   // Type bits sit above the payload
   function automatic flit_type_e flit_kind(dbg_flit_t flit);
      return flit_type_e'(flit[`DBG_FLIT_DATA_W +: `DBG_FLIT_TYPE_W]);
   endfunction

   function automatic dbg_addr_t head_dest(dbg_flit_t flit);
      return flit[`DBG_FLIT_DATA_W-1 -: `DBG_DEST_W];
   endfunction

   function automatic pkt_class_e head_class(dbg_flit_t flit);
      return pkt_class_e'(flit[`DBG_SRC_W +: `DBG_CLASS_W]);
   endfunction

   function automatic dbg_data_t make_header(
      dbg_addr_t dest,
      pkt_class_e cls,
      logic [`DBG_SRC_W-1:0] src
   );
      return {dest, cls, src};
   endfunction

endpackage

//--- hdl/dbg_ring.sv
`timescale 1ns/1ps
`include "dbg_macros.svh"

module dbg_ring import dbg_pkg::*; (
   input  logic                              clk,
   input  logic                              reset_i,
   input  dbg_flit_t [`DBG_ROUTER_COUNT-1:0] local_in_flit_i,
   input  logic [`DBG_ROUTER_COUNT-1:0]      local_in_valid_i,
   output logic [`DBG_ROUTER_COUNT-1:0]      local_in_ready_o,
   output dbg_flit_t [`DBG_ROUTER_COUNT-1:0] local_out_flit_o,
   output logic [`DBG_ROUTER_COUNT-1:0]      local_out_valid_o,
   input  logic [`DBG_ROUTER_COUNT-1:0]      local_out_ready_i
);

   localparam int N = `DBG_ROUTER_COUNT;

   // Link k carries the ring output of router k
   dbg_flit_t link_flit [N];
   logic      link_valid [N];
   logic      link_ready [N];

   for (genvar k = 0; k < N; k++) begin : g_router
      // Router 0 closes the ring from the last router
      localparam int PREV = (k + N - 1) % N;

      dbg_ring_router #(
         .ROUTER_ADDR(dbg_addr_t'(k))
      ) u_router (
         .clk               (clk),
         .reset_i           (reset_i),
         .ring_in_flit_i    (link_flit[PREV]),
         .ring_in_valid_i   (link_valid[PREV]),
         .ring_in_ready_o   (link_ready[PREV]),
         .ring_out_flit_o   (link_flit[k]),
         .ring_out_valid_o  (link_valid[k]),
         .ring_out_ready_i  (link_ready[k]),
         .local_in_flit_i   (local_in_flit_i[k]),
         .local_in_valid_i  (local_in_valid_i[k]),
         .local_in_ready_o  (local_in_ready_o[k]),
         .local_out_flit_o  (local_out_flit_o[k]),
         .local_out_valid_o (local_out_valid_o[k]),
         .local_out_ready_i (local_out_ready_i[k])
      );
   end

endmodule

//--- hdl/dbg_ring_router.sv
`timescale 1ns/1ps
`include "dbg_macros.svh"

module dbg_ring_router import dbg_pkg::*; #(
   parameter dbg_addr_t ROUTER_ADDR = '0
) (
   input  logic      clk,
   input  logic      reset_i,
   input  dbg_flit_t ring_in_flit_i,
   input  logic      ring_in_valid_i,
   output logic      ring_in_ready_o,
   output dbg_flit_t ring_out_flit_o,
   output logic      ring_out_valid_o,
   input  logic      ring_out_ready_i,
   input  dbg_flit_t local_in_flit_i,
   input  logic      local_in_valid_i,
   output logic      local_in_ready_o,
   output dbg_flit_t local_out_flit_o,
   output logic      local_out_valid_o,
   input  logic      local_out_ready_i
);

   flit_type_e ring_in_kind;
   flit_type_e fwd_kind;
   logic       ring_in_head;
   logic       to_local;
   logic       route_local_q;
   logic       lock_q;
   logic       lock_ring_q;
   logic       grant_ring;
   logic       local_load;
   logic       ring_fwd;
   logic       local_fwd;
   logic       local_take;

   assign ring_in_kind = flit_kind(ring_in_flit_i);
   assign ring_in_head = (ring_in_kind == HEADER) || (ring_in_kind == SINGLE);

   // Body flits follow the route chosen by their header
   assign to_local = ring_in_head ? (head_dest(ring_in_flit_i) == ROUTER_ADDR) : route_local_q;

   // Ring traffic wins while the ring output is unlocked
   always_comb begin
      if (lock_q) begin
         grant_ring = lock_ring_q;
      end else begin
         grant_ring = ring_in_valid_i && !to_local;
      end
   end

   // Ring output loads only when empty, so no ready path runs around the ring
   assign local_load = !local_out_valid_o || local_out_ready_i;
   assign ring_in_ready_o = to_local ? local_load : (!ring_out_valid_o && grant_ring);
   assign local_in_ready_o = !ring_out_valid_o && !grant_ring;

   assign ring_fwd = ring_in_valid_i && ring_in_ready_o && !to_local;
   assign local_fwd = local_in_valid_i && local_in_ready_o;
   assign local_take = ring_in_valid_i && ring_in_ready_o && to_local;
   assign fwd_kind = ring_fwd ? ring_in_kind : flit_kind(local_in_flit_i);

   always_ff @(posedge clk) begin
      if (reset_i) begin
         route_local_q <= 1'b0;
         lock_q <= 1'b0;
         lock_ring_q <= 1'b0;
         ring_out_valid_o <= 1'b0;
         local_out_valid_o <= 1'b0;
      end else begin
         if (ring_in_valid_i && ring_in_ready_o && ring_in_kind == HEADER) begin
            route_local_q <= to_local;
         end
         // Hold the ring output for one source from HEADER to LAST
         if (ring_fwd || local_fwd) begin
            if (fwd_kind == HEADER) begin
               lock_q <= 1'b1;
               lock_ring_q <= ring_fwd;
            end else if (fwd_kind == LAST) begin
               lock_q <= 1'b0;
            end
         end
         if (ring_fwd || local_fwd) begin
            ring_out_valid_o <= 1'b1;
         end else if (ring_out_ready_i) begin
            ring_out_valid_o <= 1'b0;
         end
         if (local_take) begin
            local_out_valid_o <= 1'b1;
         end else if (local_out_ready_i) begin
            local_out_valid_o <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (ring_fwd) begin
         ring_out_flit_o <= ring_in_flit_i;
      end else if (local_fwd) begin
         ring_out_flit_o <= local_in_flit_i;
      end
      if (local_take) begin
         local_out_flit_o <= ring_in_flit_i;
      end
   end

   // Every header on the ring names an existing router
   a_known_dest: assert property (@(posedge clk) disable iff (reset_i)
      ring_in_valid_i && ring_in_head |-> head_dest(ring_in_flit_i) < `DBG_ROUTER_COUNT);

   a_ring_out_hold: assert property (@(posedge clk) disable iff (reset_i)
      ring_out_valid_o && !ring_out_ready_i |=> ring_out_valid_o && $stable(ring_out_flit_o));

endmodule

//--- hdl/dbg_stm.sv
`timescale 1ns/1ps
`include "dbg_macros.svh"

module dbg_stm import dbg_pkg::*; (
   input  logic         clk,
   input  logic         reset_i,
   input  logic         start_edge_i,
   input  dbg_flit_t    in_flit_i,
   input  logic         in_valid_i,
   output logic         in_ready_o,
   output dbg_flit_t    out_flit_o,
   output logic         out_valid_o,
   input  logic         out_ready_i,
   input  logic         trace_valid_i,
   input  trace_id_t    trace_id_i,
   input  trace_value_t trace_value_i
);

   typedef enum logic [2:0] {
      S_IDLE,
      S_HDR,
      S_TS_HI,
      S_TS_LO,
      S_ID,
      S_VAL_HI,
      S_VAL_LO
   } state_e;

   localparam logic [`DBG_SRC_W-1:0] STM_SRC = `DBG_ADDR_STM;
   localparam dbg_addr_t TRACE_DEST = `DBG_ADDR_EXT;

   state_e       state_q;
   timestamp_t   timestamp_q;
   timestamp_t   cap_ts_q;
   trace_id_t    cap_id_q;
   trace_value_t cap_value_q;
   flit_type_e   in_kind;
   logic         in_xfer;
   logic         ctrl_pkt_q;
   logic         enable_q;
   logic         capture;

   // Control packets never stall
   assign in_ready_o = 1'b1;
   assign in_xfer = in_valid_i && in_ready_o;
   assign in_kind = flit_kind(in_flit_i);

   // Events arriving mid-packet are dropped
   assign capture = trace_valid_i && enable_q && (state_q == S_IDLE);
   assign out_valid_o = (state_q != S_IDLE);

   always_comb begin
      case (state_q)
         S_HDR:    out_flit_o = {HEADER, make_header(TRACE_DEST, CLASS_TRACE, STM_SRC)};
         S_TS_HI:  out_flit_o = {PAYLOAD, cap_ts_q[`DBG_TIMESTAMP_W-1 -: `DBG_FLIT_DATA_W]};
         S_TS_LO:  out_flit_o = {PAYLOAD, cap_ts_q[`DBG_FLIT_DATA_W-1:0]};
         S_ID:     out_flit_o = {PAYLOAD, dbg_data_t'(cap_id_q)};
         S_VAL_HI: out_flit_o = {PAYLOAD, cap_value_q[`DBG_TRACE_VALUE_W-1 -: `DBG_FLIT_DATA_W]};
         default:  out_flit_o = {LAST, cap_value_q[`DBG_FLIT_DATA_W-1:0]};
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         state_q <= S_IDLE;
         timestamp_q <= '0;
         ctrl_pkt_q <= 1'b0;
         enable_q <= 1'b0;
      end else begin
         // Global timestamp restarts with the CPU
         timestamp_q <= start_edge_i ? '0 : timestamp_q + 1'b1;
         if (in_xfer && in_kind == HEADER) begin
            ctrl_pkt_q <= (head_class(in_flit_i) == CLASS_CTRL);
         end else if (in_xfer && in_kind == LAST) begin
            ctrl_pkt_q <= 1'b0;
            if (ctrl_pkt_q) begin
               enable_q <= in_flit_i[0];
            end
         end
         case (state_q)
            S_IDLE:   if (capture) state_q <= S_HDR;
            S_HDR:    if (out_ready_i) state_q <= S_TS_HI;
            S_TS_HI:  if (out_ready_i) state_q <= S_TS_LO;
            S_TS_LO:  if (out_ready_i) state_q <= S_ID;
            S_ID:     if (out_ready_i) state_q <= S_VAL_HI;
            S_VAL_HI: if (out_ready_i) state_q <= S_VAL_LO;
            default:  if (out_ready_i) state_q <= S_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (capture) begin
         cap_ts_q <= timestamp_q;
         cap_id_q <= trace_id_i;
         cap_value_q <= trace_value_i;
      end
   end

   // Captured event stays put until its LAST flit leaves
   a_event_held: assert property (@(posedge clk) disable iff (reset_i)
      state_q != S_IDLE |=> $stable({cap_ts_q, cap_id_q, cap_value_q}));

endmodule

//--- hdl/dbg_tcm.sv
`timescale 1ns/1ps
`include "dbg_macros.svh"

module dbg_tcm import dbg_pkg::*; (
   input  logic      clk,
   input  logic      reset_i,
   input  dbg_flit_t in_flit_i,
   input  logic      in_valid_i,
   output logic      in_ready_o,
   output dbg_flit_t out_flit_o,
   output logic      out_valid_o,
   input  logic      out_ready_i,
   output logic      cpu_stall_o,
   output logic      cpu_reset_o,
   output logic      start_cpu_o,
   output logic      start_edge_o
);

   typedef enum logic [2:0] {
      S_IDLE,
      S_CTRL_DATA,
      S_REPLY_HDR,
      S_REPLY_ID,
      S_REPLY_CNT
   } state_e;

   localparam logic [`DBG_SRC_W-1:0] TCM_SRC = `DBG_ADDR_TCM;

   state_e     state_q;
   flit_type_e in_kind;
   logic       in_xfer;
   logic       ctrl_pkt_q;
   logic       start_cpu_d;
   dbg_addr_t  reply_dest_q;

   assign in_kind = flit_kind(in_flit_i);
   // No new packet while a reply is pending
   assign in_ready_o = (state_q == S_IDLE) || (state_q == S_CTRL_DATA);
   assign in_xfer = in_valid_i && in_ready_o;
   assign out_valid_o = state_q inside {S_REPLY_HDR, S_REPLY_ID, S_REPLY_CNT};
   assign start_edge_o = start_cpu_o && !start_cpu_d;

   // Info reply flits
   always_comb begin
      case (state_q)
         S_REPLY_HDR: out_flit_o = {HEADER, make_header(reply_dest_q, CLASS_INFO, TCM_SRC)};
         S_REPLY_ID:  out_flit_o = {PAYLOAD, dbg_data_t'(`DBG_SYSTEM_ID)};
         default:     out_flit_o = {LAST, dbg_data_t'(`DBG_MODULE_COUNT)};
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         state_q <= S_IDLE;
         ctrl_pkt_q <= 1'b0;
         start_cpu_d <= 1'b0;
         cpu_stall_o <= 1'b0;
         cpu_reset_o <= 1'b0;
         start_cpu_o <= 1'b0;
      end else begin
         start_cpu_d <= start_cpu_o;
         case (state_q)
            S_IDLE: begin
               if (in_xfer && in_kind == SINGLE && head_class(in_flit_i) == CLASS_INFO) begin
                  state_q <= S_REPLY_HDR;
               end else if (in_xfer && in_kind == HEADER) begin
                  // Other classes are drained without effect
                  state_q <= S_CTRL_DATA;
                  ctrl_pkt_q <= (head_class(in_flit_i) == CLASS_CTRL);
               end
            end
            S_CTRL_DATA: begin
               if (in_xfer && in_kind == LAST) begin
                  state_q <= S_IDLE;
                  if (ctrl_pkt_q) begin
                     {start_cpu_o, cpu_reset_o, cpu_stall_o} <= in_flit_i[2:0];
                  end
               end
            end
            S_REPLY_HDR: if (out_ready_i) state_q <= S_REPLY_ID;
            S_REPLY_ID:  if (out_ready_i) state_q <= S_REPLY_CNT;
            S_REPLY_CNT: if (out_ready_i) state_q <= S_IDLE;
            default:     state_q <= S_IDLE;
         endcase
      end
   end

   // Requester address, taken from the low header bits
   always_ff @(posedge clk) begin
      if (state_q == S_IDLE && in_xfer) begin
         reply_dest_q <= in_flit_i[`DBG_DEST_W-1:0];
      end
   end

endmodule

//--- hdl/debug_system.sv
`timescale 1ns/1ps
`include "dbg_macros.svh"

module debug_system import dbg_pkg::*; (
   input  logic         clk,
   input  logic         reset_i,
   input  dbg_flit_t    dbgnoc_in_flit_i,
   input  logic         dbgnoc_in_valid_i,
   output logic         dbgnoc_in_ready_o,
   output dbg_flit_t    dbgnoc_out_flit_o,
   output logic         dbgnoc_out_valid_o,
   input  logic         dbgnoc_out_ready_i,
   input  logic         trace_valid_i,
   input  trace_id_t    trace_id_i,
   input  trace_value_t trace_value_i,
   output logic         cpu_stall_o,
   output logic         cpu_reset_o,
   output logic         start_cpu_o
);

   // Local ports of the ring, indexed by router address
   dbg_flit_t [`DBG_ROUTER_COUNT-1:0] loc_in_flit;
   logic [`DBG_ROUTER_COUNT-1:0]      loc_in_valid;
   logic [`DBG_ROUTER_COUNT-1:0]      loc_in_ready;
   dbg_flit_t [`DBG_ROUTER_COUNT-1:0] loc_out_flit;
   logic [`DBG_ROUTER_COUNT-1:0]      loc_out_valid;
   logic [`DBG_ROUTER_COUNT-1:0]      loc_out_ready;
   logic                              start_edge;

   dbg_ring u_ring (
      .clk               (clk),
      .reset_i           (reset_i),
      .local_in_flit_i   (loc_in_flit),
      .local_in_valid_i  (loc_in_valid),
      .local_in_ready_o  (loc_in_ready),
      .local_out_flit_o  (loc_out_flit),
      .local_out_valid_o (loc_out_valid),
      .local_out_ready_i (loc_out_ready)
   );

   // External debug port on router 0
   assign loc_in_flit[`DBG_ADDR_EXT] = dbgnoc_in_flit_i;
   assign loc_in_valid[`DBG_ADDR_EXT] = dbgnoc_in_valid_i;
   assign dbgnoc_in_ready_o = loc_in_ready[`DBG_ADDR_EXT];
   assign dbgnoc_out_flit_o = loc_out_flit[`DBG_ADDR_EXT];
   assign dbgnoc_out_valid_o = loc_out_valid[`DBG_ADDR_EXT];
   assign loc_out_ready[`DBG_ADDR_EXT] = dbgnoc_out_ready_i;

   dbg_tcm u_tcm (
      .clk          (clk),
      .reset_i      (reset_i),
      .in_flit_i    (loc_out_flit[`DBG_ADDR_TCM]),
      .in_valid_i   (loc_out_valid[`DBG_ADDR_TCM]),
      .in_ready_o   (loc_out_ready[`DBG_ADDR_TCM]),
      .out_flit_o   (loc_in_flit[`DBG_ADDR_TCM]),
      .out_valid_o  (loc_in_valid[`DBG_ADDR_TCM]),
      .out_ready_i  (loc_in_ready[`DBG_ADDR_TCM]),
      .cpu_stall_o  (cpu_stall_o),
      .cpu_reset_o  (cpu_reset_o),
      .start_cpu_o  (start_cpu_o),
      .start_edge_o (start_edge)
   );

   dbg_stm u_stm (
      .clk           (clk),
      .reset_i       (reset_i),
      .start_edge_i  (start_edge),
      .in_flit_i     (loc_out_flit[`DBG_ADDR_STM]),
      .in_valid_i    (loc_out_valid[`DBG_ADDR_STM]),
      .in_ready_o    (loc_out_ready[`DBG_ADDR_STM]),
      .out_flit_o    (loc_in_flit[`DBG_ADDR_STM]),
      .out_valid_o   (loc_in_valid[`DBG_ADDR_STM]),
      .out_ready_i   (loc_in_ready[`DBG_ADDR_STM]),
      .trace_valid_i (trace_valid_i),
      .trace_id_i    (trace_id_i),
      .trace_value_i (trace_value_i)
   );

endmodule

//--- include/dbg_macros.svh
`ifndef DBG_MACROS_SVH
`define DBG_MACROS_SVH

// Flit layout
`define DBG_FLIT_DATA_W 16
`define DBG_FLIT_TYPE_W 2

// Header fields, destination above class above source
`define DBG_DEST_W 5
`define DBG_CLASS_W 3
`define DBG_SRC_W 8

// Ring addresses, one per router
`define DBG_ADDR_EXT 0
`define DBG_ADDR_TCM 1
`define DBG_ADDR_STM 2
`define DBG_ROUTER_COUNT 3

// System information returned by the TCM
`define DBG_SYSTEM_ID 16'hA5C3
`define DBG_MODULE_COUNT 16'd1

// Trace event widths
`define DBG_TIMESTAMP_W 32
`define DBG_TRACE_ID_W 16
`define DBG_TRACE_VALUE_W 32

`endif
